//--- rtl/mem_pkg.sv
package mem_pkg;

    typedef logic [63:0] dword_t; // data double word.
    typedef logic [31:0] word_t; // instruction or half of a double word.
    typedef logic [63:0] addr_t; // byte address.
    typedef logic [2:0]  load_op_t; // funct3 of the load.
    typedef logic [7:0]  csr_addr_t; // register offset on the csr bus.

    // funct3 load encoding, bit 2 selects zero extension
    localparam load_op_t LOAD_LB  = 3'd0;
    localparam load_op_t LOAD_LH  = 3'd1;
    localparam load_op_t LOAD_LW  = 3'd2;
    localparam load_op_t LOAD_LD  = 3'd3;
    localparam load_op_t LOAD_LBU = 3'd4;
    localparam load_op_t LOAD_LHU = 3'd5;
    localparam load_op_t LOAD_LWU = 3'd6;

    localparam csr_addr_t REG_MADDR    = 8'h00; // word index for loading.
    localparam csr_addr_t REG_WDATA_LO = 8'h04;
    localparam csr_addr_t REG_WDATA_HI = 8'h08;
    localparam csr_addr_t REG_CTRL     = 8'h0C; // bit 0 writes the word.
    localparam csr_addr_t REG_LIMIT    = 8'h10;
    localparam csr_addr_t REG_ERRCNT   = 8'h14; // read only, write clears.

endpackage

//--- rtl/mem_array.sv
`timescale 1ns/1ns

module mem_array #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         we,
    input  logic [$clog2(MEM_WORDS)-1:0] waddr,
    input  mem_pkg::dword_t              wdata,
    input  logic [$clog2(MEM_WORDS)-1:0] raddr_a,
    input  logic [$clog2(MEM_WORDS)-1:0] raddr_b,
    output mem_pkg::dword_t              rdata_a,
    output mem_pkg::dword_t              rdata_b
);

    mem_pkg::dword_t mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // both reads see the old word on a same-cycle write.
    always_ff @(posedge clk) begin
        rdata_a <= mem[raddr_a]; // fetch side.
        rdata_b <= mem[raddr_b]; // load side.
    end

endmodule

//--- rtl/fetch_port.sv
`timescale 1ns/1ns

module fetch_port #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  mem_pkg::addr_t               pc,
    input  mem_pkg::addr_t               limit,
    input  mem_pkg::dword_t              word,
    output logic [$clog2(MEM_WORDS)-1:0] word_idx,
    output mem_pkg::word_t               instr,
    output logic                         instr_err,
    output logic                         instr_valid
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic hi_q;
    logic err_q;
    logic valid_q;

    assign word_idx = pc[IDX_W+2:3]; // double word holding the instruction.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            err_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            err_q   <= (pc >= limit);
            valid_q <= 1'b1; // no wait states.
        end
    end

    always_ff @(posedge clk) begin
        hi_q <= pc[2];
    end

    assign instr       = err_q ? '0 : (hi_q ? word[63:32] : word[31:0]);
    assign instr_err   = err_q;
    assign instr_valid = valid_q;

endmodule

//--- rtl/load_port.sv
`timescale 1ns/1ns

module load_port #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         rd_en,
    input  mem_pkg::addr_t               rd_addr,
    input  mem_pkg::load_op_t            rd_op,
    input  mem_pkg::addr_t               limit,
    input  mem_pkg::dword_t              word,
    output logic [$clog2(MEM_WORDS)-1:0] word_idx,
    output mem_pkg::dword_t              rd_data,
    output logic                         rd_err,
    output logic                         rd_valid
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [2:0]        off_q;
    mem_pkg::load_op_t op_q;
    logic              en_q;
    logic              err_q;
    logic [7:0]        byte_sel;
    logic [15:0]       half_sel;
    mem_pkg::word_t    word_sel;
    mem_pkg::dword_t   ext;

    assign word_idx = rd_addr[IDX_W+2:3];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            en_q  <= 1'b0;
            err_q <= 1'b0;
        end else begin
            en_q  <= rd_en;
            err_q <= rd_en && (rd_addr >= limit);
        end
    end

    always_ff @(posedge clk) begin
        off_q <= rd_addr[2:0];
        op_q  <= rd_op;
    end

    // lane select, low address bits are dropped for the wider sizes
    always_comb begin
        byte_sel = word[{off_q, 3'b000} +: 8];
        half_sel = word[{off_q[2:1], 4'b0000} +: 16];
        word_sel = off_q[2] ? word[63:32] : word[31:0];
    end

    always_comb begin
        case (op_q)
            mem_pkg::LOAD_LB:  ext = {{56{byte_sel[7]}}, byte_sel};
            mem_pkg::LOAD_LH:  ext = {{48{half_sel[15]}}, half_sel};
            mem_pkg::LOAD_LW:  ext = {{32{word_sel[31]}}, word_sel};
            mem_pkg::LOAD_LD:  ext = word;
            mem_pkg::LOAD_LBU: ext = {56'h0, byte_sel};
            mem_pkg::LOAD_LHU: ext = {48'h0, half_sel};
            mem_pkg::LOAD_LWU: ext = {32'h0, word_sel};
            default:           ext = word; // unknown code passes the raw word.
        endcase
    end

    assign rd_data  = err_q ? '0 : ext;
    assign rd_err   = err_q;
    assign rd_valid = en_q;

endmodule

//--- rtl/mem_csr.sv
`timescale 1ns/1ns

module mem_csr #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  mem_pkg::csr_addr_t           awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [31:0]                  wdata,
    input  logic [3:0]                   wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  mem_pkg::csr_addr_t           araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [31:0]                  rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    output mem_pkg::addr_t               limit,
    output logic                         mem_we,
    output logic [$clog2(MEM_WORDS)-1:0] mem_waddr,
    output mem_pkg::dword_t              mem_wdata,
    input  logic                         fetch_err,
    input  logic                         load_err
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    typedef enum logic [1:0] {W_IDLE, W_ACK, W_RESP} wr_state_t;
    typedef enum logic [1:0] {R_IDLE, R_ACK, R_RESP} rd_state_t;

    wr_state_t        wr_state;
    rd_state_t        rd_state;
    logic             wr_fire;
    logic [31:0]      wr_val;
    logic [IDX_W-1:0] maddr_q;
    logic [31:0]      wdata_lo_q;
    logic [31:0]      wdata_hi_q;
    logic [31:0]      limit_q;
    logic [31:0]      errcnt_q;
    logic [32:0]      errcnt_sum;

    function automatic logic [31:0] reg_value(input mem_pkg::csr_addr_t a);
        case (a)
            mem_pkg::REG_MADDR:    return 32'(maddr_q);
            mem_pkg::REG_WDATA_LO: return wdata_lo_q;
            mem_pkg::REG_WDATA_HI: return wdata_hi_q;
            mem_pkg::REG_LIMIT:    return limit_q;
            mem_pkg::REG_ERRCNT:   return errcnt_q;
            default:               return 32'h0; // ctrl and holes read zero.
        endcase
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old_val, input logic [31:0] new_val,
                                          input logic [3:0] strb);
        logic [31:0] res;
        for (int i = 0; i < 4; i++) begin
            res[8*i +: 8] = strb[i] ? new_val[8*i +: 8] : old_val[8*i +: 8];
        end
        return res;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_state <= W_IDLE;
            rd_state <= R_IDLE;
        end else begin
            case (wr_state)
                W_IDLE:  wr_state <= (awvalid && wvalid) ? W_ACK : W_IDLE;
                W_ACK:   wr_state <= W_RESP;
                default: wr_state <= bready ? W_IDLE : W_RESP;
            endcase
            case (rd_state)
                R_IDLE:  rd_state <= arvalid ? R_ACK : R_IDLE;
                R_ACK:   rd_state <= R_RESP;
                default: rd_state <= rready ? R_IDLE : R_RESP;
            endcase
        end
    end

    assign wr_fire = (wr_state == W_ACK);
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign bvalid  = (wr_state == W_RESP);
    assign bresp   = 2'b00; // always okay.
    assign arready = (rd_state == R_ACK);
    assign rvalid  = (rd_state == R_RESP);
    assign rresp   = 2'b00;

    assign wr_val     = merge(reg_value(awaddr), wdata, wstrb);
    assign errcnt_sum = {1'b0, errcnt_q} + 33'(fetch_err) + 33'(load_err);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            maddr_q  <= '0;
            limit_q  <= 32'(MEM_WORDS * 8); // whole memory reachable.
            errcnt_q <= '0;
            mem_we   <= 1'b0;
        end else begin
            mem_we <= wr_fire && (awaddr == mem_pkg::REG_CTRL) && wstrb[0] && wdata[0];
            if (wr_fire && awaddr == mem_pkg::REG_MADDR) begin
                maddr_q <= wr_val[IDX_W-1:0];
            end
            if (wr_fire && awaddr == mem_pkg::REG_LIMIT) begin
                limit_q <= wr_val;
            end
            if (wr_fire && awaddr == mem_pkg::REG_ERRCNT) begin
                errcnt_q <= '0;
            end else if (errcnt_sum[32]) begin
                errcnt_q <= '1; // saturate.
            end else begin
                errcnt_q <= errcnt_sum[31:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire && awaddr == mem_pkg::REG_WDATA_LO) begin
            wdata_lo_q <= wr_val;
        end
        if (wr_fire && awaddr == mem_pkg::REG_WDATA_HI) begin
            wdata_hi_q <= wr_val;
        end
        if (rd_state == R_ACK) begin
            rdata <= reg_value(araddr);
        end
    end

    assign limit     = {32'h0, limit_q};
    assign mem_waddr = maddr_q;
    assign mem_wdata = {wdata_hi_q, wdata_lo_q};

endmodule

//--- rtl/mem_read_top.sv
`timescale 1ns/1ns

module mem_read_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic               clk,
    input  logic               arst_n,
    input  mem_pkg::csr_addr_t awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  logic [31:0]        wdata,
    input  logic [3:0]         wstrb,
    input  logic               wvalid,
    output logic               wready,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready,
    input  mem_pkg::csr_addr_t araddr,
    input  logic               arvalid,
    output logic               arready,
    output logic [31:0]        rdata,
    output logic [1:0]         rresp,
    output logic               rvalid,
    input  logic               rready,
    input  mem_pkg::addr_t     pc,
    output mem_pkg::word_t     instr,
    output logic               instr_err,
    output logic               instr_valid,
    input  logic               rd_en,
    input  mem_pkg::addr_t     rd_addr,
    input  mem_pkg::load_op_t  rd_op,
    output mem_pkg::dword_t    rd_data,
    output logic               rd_err,
    output logic               rd_valid
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    mem_pkg::addr_t   limit;
    logic             mem_we;
    logic [IDX_W-1:0] mem_waddr;
    mem_pkg::dword_t  mem_wdata;
    logic [IDX_W-1:0] fetch_idx;
    logic [IDX_W-1:0] load_idx;
    mem_pkg::dword_t  fetch_word;
    mem_pkg::dword_t  load_word;

    mem_csr #(.MEM_WORDS(MEM_WORDS)) csr_i (
        .clk(clk), .arst_n(arst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .limit(limit), .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
        .fetch_err(instr_err), .load_err(rd_err) // both ports feed the error counter.
    );

    mem_array #(.MEM_WORDS(MEM_WORDS)) mem_i (
        .clk(clk), .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata),
        .raddr_a(fetch_idx), .raddr_b(load_idx),
        .rdata_a(fetch_word), .rdata_b(load_word)
    );

    fetch_port #(.MEM_WORDS(MEM_WORDS)) fetch_i (
        .clk(clk), .arst_n(arst_n), .pc(pc), .limit(limit), .word(fetch_word),
        .word_idx(fetch_idx), .instr(instr), .instr_err(instr_err),
        .instr_valid(instr_valid)
    );

    load_port #(.MEM_WORDS(MEM_WORDS)) load_i (
        .clk(clk), .arst_n(arst_n), .rd_en(rd_en), .rd_addr(rd_addr), .rd_op(rd_op),
        .limit(limit), .word(load_word), .word_idx(load_idx),
        .rd_data(rd_data), .rd_err(rd_err), .rd_valid(rd_valid)
    );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period.
    end

    initial begin
        arst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

//--- bench/tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] instr,
    input  logic        instr_err,
    input  logic        instr_valid,
    input  logic [63:0] rd_data,
    input  logic        rd_err,
    input  logic        rd_valid,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rvalid,
    input  logic [1:0]  bresp,
    input  logic        bvalid,
    input  logic        awready,
    input  logic        wready,
    input  logic [31:0] exp_instr,
    input  logic        exp_instr_err,
    input  logic        exp_instr_valid,
    input  logic        exp_fetch_on,
    input  logic [63:0] exp_rd_data,
    input  logic        exp_rd_err,
    input  logic        exp_rd_valid,
    input  logic [31:0] exp_rdata,
    output int          checks,
    output int          errors
);

    int n_checks = 0;
    int n_errors = 0;

    assign checks = n_checks;
    assign errors = n_errors;

    task automatic check_value(input string name, input logic [63:0] want,
                               input logic [63:0] got);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, want, got);
        end
    endtask

    // outputs settle well before the falling edge.
    always @(negedge clk) begin
        if (arst_n) begin
            check_value("instr_valid", 64'(exp_instr_valid), 64'(instr_valid));
            check_value("instr_err", 64'(exp_instr_err), 64'(instr_err));
            if (exp_fetch_on) begin
                check_value("instr", 64'(exp_instr), 64'(instr));
            end
            check_value("rd_valid", 64'(exp_rd_valid), 64'(rd_valid));
            if (exp_rd_valid) begin
                check_value("rd_err", 64'(exp_rd_err), 64'(rd_err));
                check_value("rd_data", exp_rd_data, rd_data);
            end
            if (rvalid) begin
                check_value("rdata", 64'(exp_rdata), 64'(rdata));
                check_value("rresp", 64'h0, 64'(rresp));
            end
            if (bvalid) begin
                check_value("bresp", 64'h0, 64'(bresp));
            end
            if (awready) begin
                check_value("wready", 64'h1, 64'(wready)); // address and data taken together.
            end
            if (wready) begin
                check_value("awready", 64'h1, 64'(awready));
            end
        end
    end

endmodule

//--- bench/tb_assertions.sv
`timescale 1ns/1ns

module tb_assertions (
    input logic        clk,
    input logic        arst_n,
    input logic        bvalid,
    input logic        bready,
    input logic        rvalid,
    input logic        rready,
    input logic        rd_en,
    input logic        rd_valid,
    input logic        rd_err,
    input logic [63:0] rd_data
);

    bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

    // one cycle load latency.
    rd_valid_on: assert property (@(posedge clk) disable iff (!arst_n)
        rd_en |=> rd_valid) else $error("rd_valid missing one cycle after rd_en");

    rd_valid_off: assert property (@(posedge clk) disable iff (!arst_n)
        !rd_en |=> !rd_valid) else $error("rd_valid without a request");

    rd_err_zero: assert property (@(posedge clk) disable iff (!arst_n)
        rd_err |-> rd_data == 64'h0) else $error("rd_data not zero with rd_err");

endmodule

bind mem_csr tb_assertions csr_sva_i (
    .clk(clk), .arst_n(arst_n), .bvalid(bvalid), .bready(bready),
    .rvalid(rvalid), .rready(rready),
    .rd_en(1'b0), .rd_valid(1'b0), .rd_err(1'b0), .rd_data(64'h0)
);

bind load_port tb_assertions load_sva_i (
    .clk(clk), .arst_n(arst_n), .bvalid(1'b0), .bready(1'b0),
    .rvalid(1'b0), .rready(1'b0),
    .rd_en(rd_en), .rd_valid(rd_valid), .rd_err(rd_err), .rd_data(rd_data)
);

//--- bench/tb_top.sv
`timescale 1ns/1ns

module tb_top;

    localparam int MEM_WORDS   = 256;
    localparam int LOADED      = 64; // words placed by the loader.
    localparam int N_FETCH     = 100;
    localparam int N_LOADS     = 200;
    localparam int N_ERRS      = 40;
    localparam int XFER_CYCLES = 8; // bound for one register transaction.
    localparam int MAX_CYCLES  = 8 + 12 * XFER_CYCLES + LOADED * (4 * XFER_CYCLES + 1)
                                 + N_FETCH + N_LOADS + N_ERRS + 20 + 200;

    logic clk;
    logic arst_n;
    mem_pkg::csr_addr_t awaddr;
    mem_pkg::csr_addr_t araddr;
    logic        awvalid, wvalid, bready, arvalid, rready;
    logic        awready, wready, bvalid, arready, rvalid;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic [63:0] pc, rd_addr, rd_data;
    logic [31:0] instr;
    logic        instr_err, instr_valid, rd_en, rd_err, rd_valid;
    logic [2:0]  rd_op;

    logic [31:0] exp_instr, exp_rdata;
    logic        exp_instr_err, exp_instr_valid, exp_fetch_on;
    logic        exp_rd_valid, exp_rd_err;
    logic [63:0] exp_rd_data;

    logic [63:0] model_mem [MEM_WORDS];
    logic [63:0] model_limit;
    int          model_errcnt = 0;
    int          cnt_base;
    logic [15:0] lfsr;
    logic        fetch_on;
    int          cycles = 0;
    int          checks;
    int          errors;

    tb_clock clock_i (.clk(clk), .arst_n(arst_n));

    mem_read_top #(.MEM_WORDS(MEM_WORDS)) dut_i (
        .clk(clk), .arst_n(arst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .pc(pc), .instr(instr), .instr_err(instr_err), .instr_valid(instr_valid),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_op(rd_op),
        .rd_data(rd_data), .rd_err(rd_err), .rd_valid(rd_valid)
    );

    tb_checker check_i (
        .clk(clk), .arst_n(arst_n), .instr(instr), .instr_err(instr_err),
        .instr_valid(instr_valid), .rd_data(rd_data), .rd_err(rd_err), .rd_valid(rd_valid),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .bresp(bresp), .bvalid(bvalid),
        .awready(awready), .wready(wready),
        .exp_instr(exp_instr), .exp_instr_err(exp_instr_err),
        .exp_instr_valid(exp_instr_valid), .exp_fetch_on(exp_fetch_on),
        .exp_rd_data(exp_rd_data), .exp_rd_err(exp_rd_err), .exp_rd_valid(exp_rd_valid),
        .exp_rdata(exp_rdata), .checks(checks), .errors(errors)
    );

    // galois form, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] next_state(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] r;
        int          k;
        r = '0;
        for (k = 0; k < n; k++) begin
            lfsr = next_state(lfsr);
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [63:0] lane_value(input logic [63:0] addr, input logic [2:0] op);
        logic [63:0] w;
        logic [63:0] b;
        logic [63:0] h;
        logic [63:0] x;
        w = model_mem[addr[10:3]];
        b = (w >> (8 * addr[2:0])) & 64'hff;
        h = (w >> (16 * addr[2:1])) & 64'hffff;
        x = (w >> (32 * addr[2])) & 64'hffff_ffff;
        if (addr >= model_limit) begin
            return 64'h0;
        end
        case (op)
            3'd0:    return {{56{b[7]}}, b[7:0]};
            3'd1:    return {{48{h[15]}}, h[15:0]};
            3'd2:    return {{32{x[31]}}, x[31:0]};
            3'd4:    return b;
            3'd5:    return h;
            3'd6:    return x;
            default: return w; // ld and the spare code.
        endcase
    endfunction

    function automatic logic [31:0] instr_value(input logic [63:0] a);
        logic [63:0] w;
        w = model_mem[a[10:3]];
        if (a >= model_limit) begin
            return 32'h0;
        end
        return a[2] ? w[63:32] : w[31:0];
    endfunction

    task automatic write_reg(input mem_pkg::csr_addr_t a, input logic [31:0] d);
        @(posedge clk);
        awaddr  <= a;
        wdata   <= d;
        wstrb   <= 4'hf;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do begin
            @(negedge clk);
        end while (!awready);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do begin
            @(negedge clk);
        end while (!bvalid);
        @(posedge clk);
        bready <= 1'b1; // late ready, so bvalid must hold.
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic read_reg(input mem_pkg::csr_addr_t a, input logic [31:0] want);
        @(posedge clk);
        exp_rdata <= want;
        araddr    <= a;
        arvalid   <= 1'b1;
        do begin
            @(negedge clk);
        end while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        do begin
            @(negedge clk);
        end while (!rvalid);
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic program_word(input logic [7:0] idx, input logic [63:0] d);
        write_reg(mem_pkg::REG_MADDR, 32'(idx));
        write_reg(mem_pkg::REG_WDATA_LO, d[31:0]);
        write_reg(mem_pkg::REG_WDATA_HI, d[63:32]);
        write_reg(mem_pkg::REG_CTRL, 32'h1);
        model_mem[idx] = d;
    endtask

    // expected port outputs, one edge behind the requests like the dut.
    always @(posedge clk) begin
        exp_instr_valid <= arst_n;
        exp_instr_err   <= arst_n && (pc >= model_limit);
        exp_instr       <= instr_value(pc);
        exp_fetch_on    <= fetch_on;
        exp_rd_valid    <= arst_n && rd_en;
        exp_rd_err      <= arst_n && rd_en && (rd_addr >= model_limit);
        exp_rd_data     <= lane_value(rd_addr, rd_op);
        if (exp_instr_err || (exp_rd_valid && exp_rd_err)) begin
            model_errcnt <= model_errcnt + int'(exp_instr_err)
                            + int'(exp_rd_valid && exp_rd_err);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run did not finish in %0d cycles, %0d errors so far",
                     MAX_CYCLES, errors);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] v;
        lfsr        = 16'd44154;
        model_limit = 64'(MEM_WORDS * 8);
        cnt_base    = 0;
        fetch_on  <= 1'b0;
        exp_rdata <= '0;
        awaddr    <= '0;
        awvalid   <= 1'b0;
        wdata     <= '0;
        wstrb     <= '0;
        wvalid    <= 1'b0;
        bready    <= 1'b0;
        araddr    <= '0;
        arvalid   <= 1'b0;
        rready    <= 1'b0;
        pc        <= '0;
        rd_en     <= 1'b0;
        rd_addr   <= '0;
        rd_op     <= '0;
        @(posedge arst_n);

        read_reg(mem_pkg::REG_LIMIT, 32'(MEM_WORDS * 8));
        v = 32'(random_bits(8));
        write_reg(mem_pkg::REG_MADDR, v);
        read_reg(mem_pkg::REG_MADDR, v);
        v = 32'(random_bits(12)) | 32'h100;
        write_reg(mem_pkg::REG_LIMIT, v);
        read_reg(mem_pkg::REG_LIMIT, v);
        write_reg(mem_pkg::REG_LIMIT, 32'(MEM_WORDS * 8));

        for (int i = 0; i < LOADED; i++) begin
            program_word(8'(i), random_bits(64));
        end
        for (int i = 0; i < LOADED; i++) begin
            @(posedge clk);
            rd_en   <= 1'b1;
            rd_addr <= 64'(i * 8);
            rd_op   <= 3'd3;
        end
        @(posedge clk);
        rd_en    <= 1'b0;
        fetch_on <= 1'b1;

        for (int i = 0; i < N_FETCH; i++) begin
            @(posedge clk);
            pc <= random_bits(9);
        end

        for (int i = 0; i < N_LOADS; i++) begin
            @(posedge clk);
            rd_en   <= 1'b1;
            rd_addr <= random_bits(9);
            rd_op   <= 3'(random_bits(3));
            pc      <= random_bits(9);
        end
        @(posedge clk);
        rd_en <= 1'b0;
        pc    <= random_bits(8); // stays under the smaller limit.

        write_reg(mem_pkg::REG_LIMIT, 32'h100);
        model_limit = 64'h100;
        read_reg(mem_pkg::REG_ERRCNT, 32'h0);
        for (int i = 0; i < N_ERRS; i++) begin
            @(posedge clk);
            rd_en   <= 1'b1;
            rd_addr <= random_bits(10);
            rd_op   <= 3'(random_bits(3));
            pc      <= random_bits(10);
        end
        @(posedge clk);
        rd_addr <= random_bits(64) | 64'h8000_0000_0000_0000;
        pc      <= random_bits(64) | 64'h8000_0000_0000_0000;
        @(posedge clk);
        rd_en <= 1'b0;
        pc    <= random_bits(8);
        repeat (3) @(posedge clk);
        read_reg(mem_pkg::REG_ERRCNT, 32'(model_errcnt - cnt_base));
        write_reg(mem_pkg::REG_ERRCNT, 32'h0);
        cnt_base = model_errcnt;
        read_reg(mem_pkg::REG_ERRCNT, 32'(model_errcnt - cnt_base));

        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- project.f
rtl/mem_pkg.sv
rtl/mem_array.sv
rtl/fetch_port.sv
rtl/load_port.sv
rtl/mem_csr.sv
rtl/mem_read_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_assertions.sv
bench/tb_top.sv

//--- Makefile
SOURCES := $(shell cat project.f)

obj_dir/Vtb_top: project.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module tb_top -f project.f

run: obj_dir/Vtb_top
	obj_dir/Vtb_top > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
